/* rtl/pcie_cmd_settings.svh */
`ifndef PCIE_CMD_SETTINGS_SVH
`define PCIE_CMD_SETTINGS_SVH

// Host word and command layout
`define BUNDLE_W         128
`define CMD_W            32
`define PAYLOAD_W        28

// Command queue
`define FIFO_DEPTH       4
`define CMD_GAP_CYCLES   128            // Idle cycles after each ack

// DMA start
`define DMA_MAGIC        128'h30000001
`define DMA_PULSE_CYCLES 16

// Register reset values
`define WAVE_LEN_RST     14'h7ff
`define CYCLE_RST        14'h3ff
`define WAVE_FRE_RST     16'h3e8
`define ADC_CFG_RST      24'hff_ffff

`endif

/* rtl/pcie_cmd_pkg.sv */
package pcie_cmd_pkg;

    // Command opcodes, bits 31:28 of each command
    typedef enum logic [3:0] {
        OP_WAVE  = 4'h4,
        OP_IQ    = 4'h5,
        OP_ADC1  = 4'h6,
        OP_ADC2  = 4'h7,
        OP_FRE   = 4'h8,
        OP_TDATA = 4'h9,
        OP_DELAY = 4'ha,
        OP_MODE  = 4'he
    } opcode_e;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        GAP
    } split_state_e;

    typedef enum logic [1:0] {
        ARM,
        KEEP,
        DONE
    } dma_state_e;

endpackage

/* rtl/cmd_fifo.sv */
`timescale 1ns/10ps
`include "pcie_cmd_settings.svh"

module cmd_fifo #(
    parameter int WIDTH = `BUNDLE_W,
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic             clk_50m,
    input  logic             reset,
    input  logic [WIDTH-1:0] wdata,
    input  logic             wen,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             empty,
    output logic             full
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             push;
    logic             drop;

    assign push  = wen && !full;   // Writes while full are lost
    assign drop  = pop && !empty;
    assign head  = mem[rd_ptr];    // First word falls through
    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));

    always_ff @(posedge clk_50m) begin
        if (push) mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk_50m or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (drop) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            case ({push, drop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/cmd_splitter.sv */
`timescale 1ns/10ps
`include "pcie_cmd_settings.svh"

module cmd_splitter (
    input  logic                  clk_50m,
    input  logic                  reset,
    input  logic [`BUNDLE_W-1:0]  head,
    input  logic                  empty,
    output logic                  pop,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output pcie_cmd_pkg::opcode_e wb_adr,
    output logic [`PAYLOAD_W-1:0] wb_dat,
    input  logic                  wb_ack
);
    localparam int SLOTS  = `BUNDLE_W / `CMD_W;
    localparam int SLOT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
    localparam int GAP_W  = (`CMD_GAP_CYCLES > 1) ? $clog2(`CMD_GAP_CYCLES) : 1;
    localparam int OP_W   = `CMD_W - `PAYLOAD_W;
    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(SLOTS - 1);
    localparam logic [GAP_W-1:0]  GAP_LAST  = GAP_W'(`CMD_GAP_CYCLES - 1);

    pcie_cmd_pkg::split_state_e state;
    logic [`BUNDLE_W-1:0] bundle;
    logic [SLOT_W-1:0]    slot;
    logic [GAP_W-1:0]     gap_cnt;
    logic [`CMD_W-1:0]    cmd;

    ////////////////////////////////////////
    // Command presented to the bus
    ////////////////////////////////////////
    assign cmd    = bundle[slot*`CMD_W +: `CMD_W];   // Slot 0 is bits 31:0
    assign wb_adr = pcie_cmd_pkg::opcode_e'(cmd[`CMD_W-1 -: OP_W]);
    assign wb_dat = cmd[`PAYLOAD_W-1:0];
    assign wb_cyc = (state == pcie_cmd_pkg::ISSUE);
    assign wb_stb = (state == pcie_cmd_pkg::ISSUE);

    // Pop in the same cycle the head is taken
    assign pop = (state == pcie_cmd_pkg::IDLE) && !empty;

    always_ff @(posedge clk_50m) begin
        if (pop) bundle <= head;
    end

    ////////////////////////////////////////
    // Slot sequencing
    ////////////////////////////////////////
    always_ff @(posedge clk_50m or posedge reset) begin
        if (reset) begin
            state   <= pcie_cmd_pkg::IDLE;
            slot    <= '0;
            gap_cnt <= '0;
        end else begin
            case (state)
                pcie_cmd_pkg::IDLE: begin
                    if (!empty) begin
                        slot  <= '0;
                        state <= pcie_cmd_pkg::ISSUE;
                    end
                end
                pcie_cmd_pkg::ISSUE: begin
                    if (wb_ack) begin   // Held until the slave answers
                        gap_cnt <= '0;
                        state   <= pcie_cmd_pkg::GAP;
                    end
                end
                pcie_cmd_pkg::GAP: begin
                    if (gap_cnt == GAP_LAST) begin
                        if (slot == SLOT_LAST) begin
                            state <= pcie_cmd_pkg::IDLE;
                        end else begin
                            slot  <= slot + 1'b1;
                            state <= pcie_cmd_pkg::ISSUE;
                        end
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: state <= pcie_cmd_pkg::IDLE;
            endcase
        end
    end

endmodule

/* rtl/cmd_regfile.sv */
`timescale 1ns/10ps
`include "pcie_cmd_settings.svh"

module cmd_regfile (
    input  logic                  clk_50m,
    input  logic                  reset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  pcie_cmd_pkg::opcode_e wb_adr,
    input  logic [`PAYLOAD_W-1:0] wb_dat,
    output logic                  wb_ack,
    output logic [13:0]           wave_len,
    output logic [13:0]           cycle,
    output logic [19:0]           delay,
    output logic [15:0]           wave_fre,
    output logic                  tdata_start,
    output logic [3:0]            data_mode,
    output logic [3:0]            analysis_mode,
    output logic                  isa_mode_vld,
    output logic [31:0]           i0,
    output logic [31:0]           q0,
    output logic [31:0]           i1,
    output logic [31:0]           q1,
    output logic                  adc1_cfgen,
    output logic [23:0]           adc1_cfgdata,
    output logic                  adc2_cfgen,
    output logic [23:0]           adc2_cfgdata
);
    logic [15:0] iq_half [8];   // I0 lo/hi, Q0 lo/hi, I1 lo/hi, Q1 lo/hi
    logic        commit;
    logic [23:0] adc_word;

    // First cycle of a strobe
    assign commit   = wb_cyc && wb_stb && !wb_ack;
    assign adc_word = {3'b010, wb_dat[19:16], 1'b0, wb_dat[15:0]};

    always_ff @(posedge clk_50m or posedge reset) begin
        if (reset) begin
            wb_ack        <= 1'b0;
            wave_len      <= `WAVE_LEN_RST;
            cycle         <= `CYCLE_RST;
            delay         <= '0;
            wave_fre      <= `WAVE_FRE_RST;
            tdata_start   <= 1'b0;
            data_mode     <= '0;
            analysis_mode <= '0;
            isa_mode_vld  <= 1'b0;
            adc1_cfgen    <= 1'b0;
            adc1_cfgdata  <= `ADC_CFG_RST;
            adc2_cfgen    <= 1'b0;
            adc2_cfgdata  <= `ADC_CFG_RST;
            for (int k = 0; k < 8; k++) iq_half[k] <= '0;
        end else begin
            wb_ack     <= commit;
            adc1_cfgen <= 1'b0;   // Single-cycle enables
            adc2_cfgen <= 1'b0;
            if (commit) begin
                case (wb_adr)
                    pcie_cmd_pkg::OP_WAVE: begin
                        wave_len <= wb_dat[27:14];
                        cycle    <= wb_dat[13:0];
                    end
                    pcie_cmd_pkg::OP_IQ: iq_half[wb_dat[18:16]] <= wb_dat[15:0];
                    pcie_cmd_pkg::OP_ADC1: begin
                        adc1_cfgen   <= 1'b1;
                        adc1_cfgdata <= adc_word;
                    end
                    pcie_cmd_pkg::OP_ADC2: begin
                        adc2_cfgen   <= 1'b1;
                        adc2_cfgdata <= adc_word;
                    end
                    pcie_cmd_pkg::OP_FRE:   wave_fre    <= wb_dat[15:0];
                    pcie_cmd_pkg::OP_TDATA: tdata_start <= wb_dat[0];
                    pcie_cmd_pkg::OP_DELAY: delay       <= wb_dat[19:0];
                    pcie_cmd_pkg::OP_MODE: begin
                        data_mode     <= wb_dat[3:0];
                        analysis_mode <= wb_dat[7:4];
                        isa_mode_vld  <= wb_dat[8];
                    end
                    default: ;   // Unused opcodes
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // Coefficients from their halves
    ////////////////////////////////////////
    always_ff @(posedge clk_50m or posedge reset) begin
        if (reset) begin
            i0 <= '0;
            q0 <= '0;
            i1 <= '0;
            q1 <= '0;
        end else begin
            i0 <= {iq_half[1], iq_half[0]};
            q0 <= {iq_half[3], iq_half[2]};
            i1 <= {iq_half[5], iq_half[4]};
            q1 <= {iq_half[7], iq_half[6]};
        end
    end

endmodule

/* rtl/dma_start_detect.sv */
`timescale 1ns/10ps
`include "pcie_cmd_settings.svh"

module dma_start_detect (
    input  logic                 clk_50m,
    input  logic                 reset,
    input  logic [`BUNDLE_W-1:0] pxie_wdata,
    input  logic                 pxie_wen,
    input  logic                 fifo_full,
    output logic                 dma_start
);
    localparam int CNT_W = $clog2(`DMA_PULSE_CYCLES);
    localparam logic [CNT_W-1:0] KEEP_LAST = CNT_W'(`DMA_PULSE_CYCLES - 1);
    localparam logic [CNT_W-1:0] DONE_LAST = CNT_W'(1);   // Two quiet cycles

    pcie_cmd_pkg::dma_state_e state;
    logic [CNT_W-1:0]         cnt;
    logic                     hit;

    // Only words the FIFO accepts count
    assign hit       = pxie_wen && !fifo_full && (pxie_wdata == `DMA_MAGIC);
    assign dma_start = (state == pcie_cmd_pkg::KEEP);

    always_ff @(posedge clk_50m or posedge reset) begin
        if (reset) begin
            state <= pcie_cmd_pkg::ARM;
            cnt   <= '0;
        end else begin
            case (state)
                pcie_cmd_pkg::ARM: begin
                    if (hit) begin
                        cnt   <= '0;
                        state <= pcie_cmd_pkg::KEEP;
                    end
                end
                pcie_cmd_pkg::KEEP: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == KEEP_LAST) begin
                        cnt   <= '0;
                        state <= pcie_cmd_pkg::DONE;
                    end
                end
                pcie_cmd_pkg::DONE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DONE_LAST) state <= pcie_cmd_pkg::ARM;
                end
                default: state <= pcie_cmd_pkg::ARM;
            endcase
        end
    end

endmodule

/* rtl/pcie_cmd_parser.sv */
`timescale 1ns/10ps
`include "pcie_cmd_settings.svh"

module pcie_cmd_parser (
    input  logic                 clk_50m,
    input  logic                 reset,
    input  logic [`BUNDLE_W-1:0] pxie_wdata,
    input  logic                 pxie_wen,
    output logic                 fifo_full,
    output logic                 dma_start,
    output logic [13:0]          wave_len,
    output logic [13:0]          cycle,
    output logic [19:0]          delay,
    output logic [15:0]          wave_fre,
    output logic                 tdata_start,
    output logic [3:0]           data_mode,
    output logic [3:0]           analysis_mode,
    output logic                 isa_mode_vld,
    output logic [31:0]          i0,
    output logic [31:0]          q0,
    output logic [31:0]          i1,
    output logic [31:0]          q1,
    output logic                 adc1_cfgen,
    output logic [23:0]          adc1_cfgdata,
    output logic                 adc2_cfgen,
    output logic [23:0]          adc2_cfgdata
);
    logic [`BUNDLE_W-1:0]  head;
    logic                  empty;
    logic                  pop;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_ack;
    pcie_cmd_pkg::opcode_e wb_adr;
    logic [`PAYLOAD_W-1:0] wb_dat;

    cmd_fifo cmd_fifo_i (
        .clk_50m (clk_50m),
        .reset   (reset),
        .wdata   (pxie_wdata),
        .wen     (pxie_wen),
        .pop     (pop),
        .head    (head),
        .empty   (empty),
        .full    (fifo_full)
    );

    // Wishbone master
    cmd_splitter cmd_splitter_i (
        .clk_50m (clk_50m),
        .reset   (reset),
        .head    (head),
        .empty   (empty),
        .pop     (pop),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_adr  (wb_adr),
        .wb_dat  (wb_dat),
        .wb_ack  (wb_ack)
    );

    // Wishbone slave
    cmd_regfile cmd_regfile_i (
        .clk_50m       (clk_50m),
        .reset         (reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_adr        (wb_adr),
        .wb_dat        (wb_dat),
        .wb_ack        (wb_ack),
        .wave_len      (wave_len),
        .cycle         (cycle),
        .delay         (delay),
        .wave_fre      (wave_fre),
        .tdata_start   (tdata_start),
        .data_mode     (data_mode),
        .analysis_mode (analysis_mode),
        .isa_mode_vld  (isa_mode_vld),
        .i0            (i0),
        .q0            (q0),
        .i1            (i1),
        .q1            (q1),
        .adc1_cfgen    (adc1_cfgen),
        .adc1_cfgdata  (adc1_cfgdata),
        .adc2_cfgen    (adc2_cfgen),
        .adc2_cfgdata  (adc2_cfgdata)
    );

    // Watches the host word ahead of the FIFO
    dma_start_detect dma_start_detect_i (
        .clk_50m    (clk_50m),
        .reset      (reset),
        .pxie_wdata (pxie_wdata),
        .pxie_wen   (pxie_wen),
        .fifo_full  (fifo_full),
        .dma_start  (dma_start)
    );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_50m,
    output logic reset
);
    initial begin
        clk_50m = 1'b0;
        forever #10 clk_50m = ~clk_50m;   // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk_50m);
        #2;
        reset = 1'b0;
    end

endmodule

/* dv/pcie_cmd_parser_assert.sv */
`timescale 1ns/10ps

module pcie_cmd_parser_assert (
    input logic clk_50m,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic adc1_cfgen,
    input logic adc2_cfgen,
    input logic dma_start
);
    logic [4:0] dma_run;   // High cycles of dma_start so far

    always_ff @(posedge clk_50m or posedge reset) begin
        if (reset) begin
            dma_run <= '0;
        end else if (dma_start) begin
            dma_run <= dma_run + 1'b1;
        end else begin
            dma_run <= '0;
        end
    end

    ////////////////////////////////////////
    // Bus and pulse rules
    ////////////////////////////////////////
    stb_needs_cyc: assert property (@(posedge clk_50m) disable iff (reset) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    ack_needs_stb: assert property (@(posedge clk_50m) disable iff (reset) wb_ack |-> wb_stb)
        else $error("wb_ack high without wb_stb");

    adc1_single: assert property (@(posedge clk_50m) disable iff (reset)
        adc1_cfgen |-> !$past(adc1_cfgen))
        else $error("adc1_cfgen high two cycles in a row");

    adc2_single: assert property (@(posedge clk_50m) disable iff (reset)
        adc2_cfgen |-> !$past(adc2_cfgen))
        else $error("adc2_cfgen high two cycles in a row");

    dma_len: assert property (@(posedge clk_50m) disable iff (reset)
        dma_start |-> (dma_run < 5'd16))
        else $error("dma_start high longer than 16 cycles");

endmodule

bind pcie_cmd_parser pcie_cmd_parser_assert pcie_cmd_parser_assert_i (
    .clk_50m    (clk_50m),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .adc1_cfgen (adc1_cfgen),
    .adc2_cfgen (adc2_cfgen),
    .dma_start  (dma_start)
);

/* dv/tb_pcie_cmd_parser.sv */
`timescale 1ns/10ps
`include "pcie_cmd_settings.svh"

module tb_pcie_cmd_parser;
    localparam int BUNDLE_CYCLES = 1 + 4 * (2 + `CMD_GAP_CYCLES);

    logic                 clk_50m;
    logic                 reset;
    logic [`BUNDLE_W-1:0] pxie_wdata;
    logic                 pxie_wen;
    logic                 fifo_full, dma_start, tdata_start, isa_mode_vld;
    logic                 adc1_cfgen, adc2_cfgen;
    logic [13:0]          wave_len, cycle;
    logic [19:0]          delay;
    logic [15:0]          wave_fre;
    logic [3:0]           data_mode, analysis_mode;
    logic [31:0]          i0, q0, i1, q1;
    logic [23:0]          adc1_cfgdata, adc2_cfgdata;

    // Register model
    logic [13:0] m_wave_len, m_cycle;
    logic [19:0] m_delay;
    logic [15:0] m_wave_fre;
    logic        m_tdata_start, m_isa_mode_vld;
    logic [3:0]  m_data_mode, m_analysis_mode;
    logic [15:0] m_iq_half [8];
    logic [23:0] m_adc1_cfgdata, m_adc2_cfgdata;

    logic [31:0] lfsr = 32'hb2fc;
    int          cycle_cnt = 0;
    int          test_start = 0;
    int          cycle_limit = 0;
    int          adc_pulses = 0;
    logic        check_req = 1'b0;
    logic        check_adc_data = 1'b0;
    logic        adc1_prev = 1'b0;
    logic        adc2_prev = 1'b0;

    tb_clk_gen tb_clk_gen_i (.clk_50m(clk_50m), .reset(reset));

    pcie_cmd_parser pcie_cmd_parser_i (.*);

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else report_failure($sformatf(
            "Fail at %0t: %s expected 'h%0h actual 'h%0h", $time, name, exp, act));
    endtask

    ////////////////////////////////////////
    // Random payloads
    ////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] random_cmd(input logic [3:0] op);
        logic [31:0] r;
        r = rand_bits(28);
        return {op, r[27:0]};
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic void reset_model();
        m_wave_len      = `WAVE_LEN_RST;
        m_cycle         = `CYCLE_RST;
        m_delay         = '0;
        m_wave_fre      = `WAVE_FRE_RST;
        m_tdata_start   = 1'b0;
        m_data_mode     = '0;
        m_analysis_mode = '0;
        m_isa_mode_vld  = 1'b0;
        m_adc1_cfgdata  = `ADC_CFG_RST;
        m_adc2_cfgdata  = `ADC_CFG_RST;
        for (int k = 0; k < 8; k++) m_iq_half[k] = '0;
    endfunction

    function automatic void apply_cmd(input logic [3:0] op, input logic [27:0] pl);
        case (op)
            pcie_cmd_pkg::OP_WAVE: begin
                m_wave_len = pl[27:14];
                m_cycle    = pl[13:0];
            end
            pcie_cmd_pkg::OP_IQ:    m_iq_half[pl[18:16]] = pl[15:0];
            pcie_cmd_pkg::OP_ADC1:  m_adc1_cfgdata = {3'b010, pl[19:16], 1'b0, pl[15:0]};
            pcie_cmd_pkg::OP_ADC2:  m_adc2_cfgdata = {3'b010, pl[19:16], 1'b0, pl[15:0]};
            pcie_cmd_pkg::OP_FRE:   m_wave_fre = pl[15:0];
            pcie_cmd_pkg::OP_TDATA: m_tdata_start = pl[0];
            pcie_cmd_pkg::OP_DELAY: m_delay = pl[19:0];
            pcie_cmd_pkg::OP_MODE: begin
                m_data_mode     = pl[3:0];
                m_analysis_mode = pl[7:4];
                m_isa_mode_vld  = pl[8];
            end
            default: ;
        endcase
    endfunction

    function automatic void apply_bundle(input logic [`BUNDLE_W-1:0] b);
        for (int k = 0; k < 4; k++) apply_cmd(b[k*32+28 +: 4], b[k*32 +: 28]);
    endfunction

    ////////////////////////////////////////
    // Stimulus and waits
    ////////////////////////////////////////
    task automatic write_word(input logic [`BUNDLE_W-1:0] b, output logic acc);
        pxie_wdata = b;
        pxie_wen   = 1'b1;
        acc        = !fifo_full;   // What the next edge sees
        @(posedge clk_50m);
        #2;
        pxie_wen = 1'b0;
    endtask

    task automatic send_bundle(input logic [`BUNDLE_W-1:0] b);
        logic acc;
        write_word(b, acc);
        assert (acc) else report_failure("Bundle was dropped by a full FIFO");
        apply_bundle(b);
    endtask

    task automatic begin_test(input int bundles);
        test_start  = cycle_cnt;
        cycle_limit = (bundles + 2) * BUNDLE_CYCLES + 200;
    endtask

    // FIFO empty and no strobe for a whole bundle time
    task automatic wait_settled();
        int quiet;
        quiet = 0;
        while (quiet < BUNDLE_CYCLES + 2) begin
            @(negedge clk_50m);
            if (pcie_cmd_parser_i.empty && !pcie_cmd_parser_i.wb_cyc) quiet++;
            else quiet = 0;
        end
        @(posedge clk_50m);
        #2;
    endtask

    task automatic request_compare();
        check_req = 1'b1;
        wait (check_req === 1'b0);
        @(posedge clk_50m);
        #2;
    endtask

    task automatic compare_all();
        check_value("wave_len", 32'(m_wave_len), 32'(wave_len));
        check_value("cycle", 32'(m_cycle), 32'(cycle));
        check_value("delay", 32'(m_delay), 32'(delay));
        check_value("wave_fre", 32'(m_wave_fre), 32'(wave_fre));
        check_value("tdata_start", 32'(m_tdata_start), 32'(tdata_start));
        check_value("data_mode", 32'(m_data_mode), 32'(data_mode));
        check_value("analysis_mode", 32'(m_analysis_mode), 32'(analysis_mode));
        check_value("isa_mode_vld", 32'(m_isa_mode_vld), 32'(isa_mode_vld));
        check_value("i0", {m_iq_half[1], m_iq_half[0]}, i0);
        check_value("q0", {m_iq_half[3], m_iq_half[2]}, q0);
        check_value("i1", {m_iq_half[5], m_iq_half[4]}, i1);
        check_value("q1", {m_iq_half[7], m_iq_half[6]}, q1);
        check_value("adc1_cfgdata", 32'(m_adc1_cfgdata), 32'(adc1_cfgdata));
        check_value("adc2_cfgdata", 32'(m_adc2_cfgdata), 32'(adc2_cfgdata));
        check_value("adc1_cfgen", 32'h0, 32'(adc1_cfgen));
        check_value("adc2_cfgen", 32'h0, 32'(adc2_cfgen));
        check_value("dma_start", 32'h0, 32'(dma_start));
        check_value("fifo_full", 32'h0, 32'(fifo_full));
    endtask

    ////////////////////////////////////////
    // Checking processes
    ////////////////////////////////////////
    always @(negedge clk_50m) begin
        if (check_req) begin
            compare_all();
            check_req = 1'b0;
        end
    end

    // ADC enable pulses
    always @(negedge clk_50m) begin
        if (reset === 1'b0) begin
            assert (!(adc1_cfgen && adc1_prev))
                else report_failure("adc1_cfgen lasted two cycles");
            assert (!(adc2_cfgen && adc2_prev))
                else report_failure("adc2_cfgen lasted two cycles");
            if (adc1_cfgen) begin
                adc_pulses++;
                if (check_adc_data) begin
                    check_value("adc1_cfgdata", 32'(m_adc1_cfgdata), 32'(adc1_cfgdata));
                end
            end
            if (adc2_cfgen) begin
                adc_pulses++;
                if (check_adc_data) begin
                    check_value("adc2_cfgdata", 32'(m_adc2_cfgdata), 32'(adc2_cfgdata));
                end
            end
        end
        adc1_prev = adc1_cfgen;
        adc2_prev = adc2_cfgen;
    end

    always @(posedge clk_50m) begin
        cycle_cnt++;
        if (cycle_cnt - test_start > cycle_limit) begin
            report_failure($sformatf(
                "Timeout after %0d cycles without the DUT settling", cycle_limit));
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        logic [`BUNDLE_W-1:0] b;
        logic [31:0]          p;
        logic [31:0]          idx;
        logic                 acc;
        int                   pulse_base;
        int                   run;
        logic [3:0]           ops [8];

        pxie_wdata = '0;
        pxie_wen   = 1'b0;
        reset_model();
        begin_test(0);   // Reset values
        ops = '{pcie_cmd_pkg::OP_WAVE, pcie_cmd_pkg::OP_IQ, pcie_cmd_pkg::OP_ADC1,
                pcie_cmd_pkg::OP_ADC2, pcie_cmd_pkg::OP_FRE, pcie_cmd_pkg::OP_TDATA,
                pcie_cmd_pkg::OP_DELAY, pcie_cmd_pkg::OP_MODE};
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        @(posedge clk_50m);
        #2;

        request_compare();

        begin_test(1);
        b = {random_cmd(pcie_cmd_pkg::OP_MODE), random_cmd(pcie_cmd_pkg::OP_DELAY),
             random_cmd(pcie_cmd_pkg::OP_FRE), random_cmd(pcie_cmd_pkg::OP_WAVE)};
        send_bundle(b);
        wait_settled();
        request_compare();

        begin_test(2);   // All eight I/Q halves
        for (int n = 0; n < 2; n++) begin
            for (int k = 0; k < 4; k++) begin
                p = random_cmd(pcie_cmd_pkg::OP_IQ);
                p[18:16] = 3'(n * 4 + k);
                b[k*32 +: 32] = p;
            end
            send_bundle(b);
        end
        wait_settled();
        request_compare();

        begin_test(1);   // ADC pulses, tdata and opcode c
        p = random_cmd(pcie_cmd_pkg::OP_TDATA);
        p[0] = 1'b1;
        b = {random_cmd(4'hc), p, random_cmd(pcie_cmd_pkg::OP_ADC2),
             random_cmd(pcie_cmd_pkg::OP_ADC1)};
        pulse_base     = adc_pulses;
        check_adc_data = 1'b1;
        send_bundle(b);
        wait_settled();
        check_adc_data = 1'b0;
        check_value("adc pulse count", 32'd2, 32'(adc_pulses - pulse_base));
        request_compare();

        begin_test(1);   // DMA start
        assert (dma_start === 1'b0) else report_failure("dma_start high before the DMA word");
        send_bundle(`DMA_MAGIC);
        @(negedge clk_50m);
        run = 0;
        while (dma_start === 1'b1 && run < 40) begin
            run++;
            @(negedge clk_50m);
        end
        check_value("dma_start cycles", 32'(`DMA_PULSE_CYCLES), 32'(run));
        wait_settled();
        request_compare();

        begin_test(6);   // Back to back, some dropped
        for (int n = 0; n < 6; n++) begin
            for (int k = 0; k < 4; k++) begin
                idx = rand_bits(3);
                b[k*32 +: 32] = random_cmd(ops[idx[2:0]]);
            end
            write_word(b, acc);
            if (acc) apply_bundle(b);
        end
        wait_settled();
        request_compare();

        $display("Regression passed");
        $finish;
    end

endmodule

/* src.f */
+incdir+rtl
rtl/pcie_cmd_pkg.sv
rtl/cmd_fifo.sv
rtl/cmd_splitter.sv
rtl/cmd_regfile.sv
rtl/dma_start_detect.sv
rtl/pcie_cmd_parser.sv
dv/tb_clk_gen.sv
dv/pcie_cmd_parser_assert.sv
dv/tb_pcie_cmd_parser.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f \
    --top-module tb_pcie_cmd_parser -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
